// ==== source/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

`define CPU_XLEN     32
`define CPU_REG_AW   5
`define CPU_RESET_PC 32'h0000_0000

// primary opcodes in inst[31:26]
`define OP_SPECIAL 6'h00
`define OP_BEQ     6'h04
`define OP_BNE     6'h05
`define OP_ADDIU   6'h09
`define OP_ORI     6'h0d
`define OP_LUI     6'h0f
`define OP_LW      6'h23
`define OP_SW      6'h2b

// funct field of SPECIAL
`define FN_ADDU 6'h21
`define FN_SUBU 6'h23
`define FN_AND  6'h24
`define FN_OR   6'h25
`define FN_XOR  6'h26
`define FN_SLT  6'h2a

`endif

// ==== source/cpu_pkg.sv ====
`include "cpu_cfg.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0]   word_t;
    typedef logic [`CPU_REG_AW-1:0] reg_addr_t;
    typedef logic [31:0]            inst_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    // where a decode operand comes from
    typedef enum logic [1:0] {
        FWD_RF,
        FWD_EX,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    typedef struct packed {
        logic  valid;
        word_t pc;
        inst_t inst;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        alu_op_e   alu_op;
        word_t     op_a;
        word_t     op_b;
        word_t     rt_val;
        reg_addr_t dest;
        logic      reg_we;
        logic      is_load;
        logic      is_store;
        logic      is_branch;
        logic      branch_ne;
        word_t     target;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     result;
        word_t     sdata;
        reg_addr_t dest;
        logic      reg_we;
        logic      is_load;
        logic      is_store;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     wdata;
        reg_addr_t dest;
        logic      reg_we;
    } mem_wb_t;

endpackage

// ==== source/fetch_stage.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module fetch_stage (
    input  logic            clk,
    input  logic            rst,
    input  logic            en,
    input  logic            branch_taken,
    input  cpu_pkg::word_t  branch_target,
    input  logic            flush,
    output cpu_pkg::word_t  inst_addr,
    input  cpu_pkg::inst_t  inst_line,
    output cpu_pkg::if_id_t if_id
);

    cpu_pkg::word_t pc;

    // instruction memory answers in the same cycle
    assign inst_addr = pc;

    always_ff @(posedge clk)
    begin
        if (rst)
            pc <= `CPU_RESET_PC;
        else if (en)
            pc <= branch_taken ? branch_target : pc + 32'd4;
    end

    always_ff @(posedge clk)
    begin
        if (rst || flush)
            if_id <= '0;
        else if (en)
        begin
            if_id.valid <= 1'b1;
            if_id.pc    <= pc;
            if_id.inst  <= inst_line;
        end
    end

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  cpu_pkg::reg_addr_t ra,
    input  cpu_pkg::reg_addr_t rb,
    output cpu_pkg::word_t     rdata_a,
    output cpu_pkg::word_t     rdata_b,
    input  cpu_pkg::mem_wb_t   wb
);

    localparam int NUM_REGS = 1 << `CPU_REG_AW;

    cpu_pkg::word_t regs [NUM_REGS];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (wb.valid && wb.reg_we && wb.dest != '0)
            regs[wb.dest] <= wb.wdata;
    end

    // r0 reads as zero, no write-through here
    assign rdata_a = (ra == '0) ? '0 : regs[ra];
    assign rdata_b = (rb == '0) ? '0 : regs[rb];

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module decode_stage (
    input  logic               clk,
    input  logic               rst,
    input  logic               en,
    input  logic               flush,
    input  cpu_pkg::if_id_t    if_id,
    input  cpu_pkg::word_t     rf_a,
    input  cpu_pkg::word_t     rf_b,
    input  cpu_pkg::word_t     ex_fwd,
    input  cpu_pkg::word_t     mem_fwd,
    input  cpu_pkg::word_t     wb_fwd,
    input  cpu_pkg::fwd_sel_e  fwd_a,
    input  cpu_pkg::fwd_sel_e  fwd_b,
    output cpu_pkg::reg_addr_t rs,
    output cpu_pkg::reg_addr_t rt,
    output logic               uses_rs,
    output logic               uses_rt,
    output cpu_pkg::id_ex_t    id_ex
);

    logic [5:0]         opcode;
    logic [5:0]         funct;
    cpu_pkg::reg_addr_t rd;
    cpu_pkg::word_t     imm_sext;
    cpu_pkg::word_t     imm_zext;
    cpu_pkg::word_t     pc_next;
    cpu_pkg::word_t     val_a;
    cpu_pkg::word_t     val_b;
    cpu_pkg::id_ex_t    dec;

    function automatic cpu_pkg::word_t pick(input cpu_pkg::fwd_sel_e sel,
                                            input cpu_pkg::word_t rf_val);
        case (sel)
            cpu_pkg::FWD_EX:  pick = ex_fwd;
            cpu_pkg::FWD_MEM: pick = mem_fwd;
            cpu_pkg::FWD_WB:  pick = wb_fwd;
            default:          pick = rf_val;
        endcase
    endfunction

    assign opcode   = if_id.inst[31:26];
    assign funct    = if_id.inst[5:0];
    assign rs       = if_id.inst[25:21];
    assign rt       = if_id.inst[20:16];
    assign rd       = if_id.inst[15:11];
    assign imm_sext = {{16{if_id.inst[15]}}, if_id.inst[15:0]};
    assign imm_zext = {16'h0000, if_id.inst[15:0]};
    assign pc_next  = if_id.pc + 32'd4;

    always_comb
    begin
        val_a = pick(fwd_a, rf_a);
        val_b = pick(fwd_b, rf_b);

        // I-type add with sign-extended immediate unless told otherwise
        dec        = '0;
        dec.valid  = if_id.valid;
        dec.pc     = if_id.pc;
        dec.alu_op = cpu_pkg::ALU_ADD;
        dec.op_a   = val_a;
        dec.op_b   = imm_sext;
        dec.rt_val = val_b;
        dec.dest   = rt;
        dec.target = pc_next + {imm_sext[29:0], 2'b00};
        uses_rs    = 1'b1;
        uses_rt    = 1'b0;

        case (opcode)
            `OP_SPECIAL:
            begin
                dec.op_b   = val_b;
                dec.dest   = rd;
                dec.reg_we = 1'b1;
                uses_rt    = 1'b1;
                case (funct)
                    `FN_ADDU: dec.alu_op = cpu_pkg::ALU_ADD;
                    `FN_SUBU: dec.alu_op = cpu_pkg::ALU_SUB;
                    `FN_AND:  dec.alu_op = cpu_pkg::ALU_AND;
                    `FN_OR:   dec.alu_op = cpu_pkg::ALU_OR;
                    `FN_XOR:  dec.alu_op = cpu_pkg::ALU_XOR;
                    `FN_SLT:  dec.alu_op = cpu_pkg::ALU_SLT;
                    // outside the subset, runs as a nop
                    default:  dec.reg_we = 1'b0;
                endcase
            end
            `OP_ADDIU:
                dec.reg_we = 1'b1;
            `OP_ORI:
            begin
                dec.alu_op = cpu_pkg::ALU_OR;
                dec.op_b   = imm_zext;
                dec.reg_we = 1'b1;
            end
            `OP_LUI:
            begin
                dec.alu_op = cpu_pkg::ALU_LUI;
                dec.op_b   = imm_zext;
                dec.reg_we = 1'b1;
                uses_rs    = 1'b0;
            end
            `OP_LW:
            begin
                dec.reg_we  = 1'b1;
                dec.is_load = 1'b1;
            end
            `OP_SW:
            begin
                dec.is_store = 1'b1;
                uses_rt      = 1'b1;
            end
            `OP_BEQ, `OP_BNE:
            begin
                dec.op_b      = val_b;
                dec.is_branch = 1'b1;
                dec.branch_ne = (opcode == `OP_BNE);
                uses_rt       = 1'b1;
            end
            default:
                uses_rs = 1'b0;
        endcase

        if (dec.dest == '0)
            dec.reg_we = 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (rst || flush)
            id_ex <= '0;
        else if (en)
            id_ex <= dec;
    end

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module execute_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             en,
    input  logic             flush,
    input  cpu_pkg::id_ex_t  id_ex,
    output cpu_pkg::word_t   result,
    output logic             branch_taken,
    output cpu_pkg::word_t   branch_target,
    output cpu_pkg::ex_mem_t ex_mem
);

    logic less;

    assign less = $signed(id_ex.op_a) < $signed(id_ex.op_b);

    // loads and stores use the add for their address
    always_comb
    begin
        case (id_ex.alu_op)
            cpu_pkg::ALU_SUB: result = id_ex.op_a - id_ex.op_b;
            cpu_pkg::ALU_AND: result = id_ex.op_a & id_ex.op_b;
            cpu_pkg::ALU_OR:  result = id_ex.op_a | id_ex.op_b;
            cpu_pkg::ALU_XOR: result = id_ex.op_a ^ id_ex.op_b;
            cpu_pkg::ALU_SLT: result = {{(`CPU_XLEN-1){1'b0}}, less};
            cpu_pkg::ALU_LUI: result = {id_ex.op_b[15:0], 16'h0000};
            default:          result = id_ex.op_a + id_ex.op_b;
        endcase
    end

    assign branch_taken  = id_ex.valid && id_ex.is_branch &&
                           ((id_ex.op_a == id_ex.op_b) != id_ex.branch_ne);
    assign branch_target = id_ex.target;

    always_ff @(posedge clk)
    begin
        if (rst || flush)
            ex_mem <= '0;
        else if (en)
        begin
            ex_mem.valid    <= id_ex.valid;
            ex_mem.pc       <= id_ex.pc;
            ex_mem.result   <= result;
            ex_mem.sdata    <= id_ex.rt_val;
            ex_mem.dest     <= id_ex.dest;
            ex_mem.reg_we   <= id_ex.reg_we;
            ex_mem.is_load  <= id_ex.is_load;
            ex_mem.is_store <= id_ex.is_store;
        end
    end

endmodule

// ==== source/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             en,
    input  cpu_pkg::ex_mem_t ex_mem,
    output logic             data_valid,
    input  logic             data_ready,
    output logic             data_wr,
    output logic [1:0]       data_size,
    output logic [3:0]       data_wstrb,
    output cpu_pkg::word_t   data_addr,
    output cpu_pkg::word_t   data_wdata,
    input  cpu_pkg::word_t   data_rdata,
    output cpu_pkg::word_t   fwd_value,
    output cpu_pkg::mem_wb_t mem_wb
);

    // request stays up with EX/MEM frozen until ready
    assign data_valid = ex_mem.valid && (ex_mem.is_load || ex_mem.is_store);
    assign data_wr    = ex_mem.is_store;
    assign data_size  = 2'b10;
    assign data_wstrb = ex_mem.is_store ? 4'hf : 4'h0;
    assign data_addr  = ex_mem.result;
    assign data_wdata = ex_mem.sdata;

    // load data only counts in the completing cycle
    assign fwd_value = (ex_mem.is_load && data_ready) ? data_rdata : ex_mem.result;

    always_ff @(posedge clk)
    begin
        if (rst)
            mem_wb <= '0;
        else if (en)
        begin
            mem_wb.valid  <= ex_mem.valid;
            mem_wb.pc     <= ex_mem.pc;
            mem_wb.wdata  <= fwd_value;
            mem_wb.dest   <= ex_mem.dest;
            mem_wb.reg_we <= ex_mem.reg_we;
        end
        else
            // waiting on the bus, writeback gets a bubble
            mem_wb <= '0;
    end

endmodule

// ==== source/pipe_ctrl.sv ====
`timescale 1ns/1ps

module pipe_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  cpu_pkg::reg_addr_t rs,
    input  cpu_pkg::reg_addr_t rt,
    input  logic               uses_rs,
    input  logic               uses_rt,
    input  cpu_pkg::id_ex_t    id_ex,
    input  cpu_pkg::ex_mem_t   ex_mem,
    input  cpu_pkg::mem_wb_t   mem_wb,
    input  logic               branch_taken,
    input  logic               data_valid,
    input  logic               data_ready,
    output logic               fetch_en,
    output logic               decode_en,
    output logic               decode_flush,
    output logic               execute_en,
    output logic               execute_flush,
    output logic               mem_en,
    output cpu_pkg::fwd_sel_e  fwd_a,
    output cpu_pkg::fwd_sel_e  fwd_b
);

    logic running;
    logic go;
    logic load_use;
    logic redirect;

    // first cycle out of reset holds every stage
    always_ff @(posedge clk)
    begin
        if (rst)
            running <= 1'b0;
        else
            running <= 1'b1;
    end

    assign go = running && !(data_valid && !data_ready);

    assign load_use = id_ex.valid && id_ex.is_load && id_ex.dest != '0 &&
                      ((uses_rs && id_ex.dest == rs) || (uses_rt && id_ex.dest == rt));

    assign redirect = go && branch_taken;

    assign fetch_en      = go && !load_use;
    assign decode_en     = go;
    assign decode_flush  = redirect || (go && load_use);
    assign execute_en    = go;
    // the branch has no work past execute, the fetched one is dropped
    assign execute_flush = redirect;
    assign mem_en        = go;

    // youngest producer wins
    function automatic cpu_pkg::fwd_sel_e src_of(input cpu_pkg::reg_addr_t r);
        if (r == '0)
            src_of = cpu_pkg::FWD_RF;
        else if (id_ex.valid && id_ex.reg_we && id_ex.dest == r)
            src_of = cpu_pkg::FWD_EX;
        else if (ex_mem.valid && ex_mem.reg_we && ex_mem.dest == r)
            src_of = cpu_pkg::FWD_MEM;
        else if (mem_wb.valid && mem_wb.reg_we && mem_wb.dest == r)
            src_of = cpu_pkg::FWD_WB;
        else
            src_of = cpu_pkg::FWD_RF;
    endfunction

    always_comb
    begin
        fwd_a = src_of(rs);
        fwd_b = src_of(rt);
    end

endmodule

// ==== source/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
    input  logic               clk,
    input  logic               rst,
    output cpu_pkg::word_t     inst_addr,
    input  cpu_pkg::inst_t     inst_line,
    output logic               data_valid,
    input  logic               data_ready,
    output logic               data_wr,
    output logic [1:0]         data_size,
    output logic [3:0]         data_wstrb,
    output cpu_pkg::word_t     data_addr,
    output cpu_pkg::word_t     data_wdata,
    input  cpu_pkg::word_t     data_rdata,
    output cpu_pkg::word_t     debug_wb_pc,
    output logic [3:0]         debug_wb_rf_wen,
    output cpu_pkg::reg_addr_t debug_wb_rf_wnum,
    output cpu_pkg::word_t     debug_wb_rf_wdata
);

    cpu_pkg::if_id_t    if_id;
    cpu_pkg::id_ex_t    id_ex;
    cpu_pkg::ex_mem_t   ex_mem;
    cpu_pkg::mem_wb_t   mem_wb;
    cpu_pkg::reg_addr_t rs;
    cpu_pkg::reg_addr_t rt;
    logic               uses_rs;
    logic               uses_rt;
    cpu_pkg::word_t     rf_a;
    cpu_pkg::word_t     rf_b;
    cpu_pkg::word_t     ex_result;
    cpu_pkg::word_t     mem_value;
    logic               branch_taken;
    cpu_pkg::word_t     branch_target;
    logic               fetch_en;
    logic               decode_en;
    logic               decode_flush;
    logic               execute_en;
    logic               execute_flush;
    logic               mem_en;
    cpu_pkg::fwd_sel_e  fwd_a;
    cpu_pkg::fwd_sel_e  fwd_b;

    fetch_stage u_fetch (
        .clk           (clk),
        .rst           (rst),
        .en            (fetch_en),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .flush         (execute_flush),
        .inst_addr     (inst_addr),
        .inst_line     (inst_line),
        .if_id         (if_id)
    );

    reg_file u_rf (
        .clk     (clk),
        .rst     (rst),
        .ra      (rs),
        .rb      (rt),
        .rdata_a (rf_a),
        .rdata_b (rf_b),
        .wb      (mem_wb)
    );

    decode_stage u_decode (
        .clk     (clk),
        .rst     (rst),
        .en      (decode_en),
        .flush   (decode_flush),
        .if_id   (if_id),
        .rf_a    (rf_a),
        .rf_b    (rf_b),
        .ex_fwd  (ex_result),
        .mem_fwd (mem_value),
        .wb_fwd  (mem_wb.wdata),
        .fwd_a   (fwd_a),
        .fwd_b   (fwd_b),
        .rs      (rs),
        .rt      (rt),
        .uses_rs (uses_rs),
        .uses_rt (uses_rt),
        .id_ex   (id_ex)
    );

    execute_stage u_execute (
        .clk           (clk),
        .rst           (rst),
        .en            (execute_en),
        .flush         (execute_flush),
        .id_ex         (id_ex),
        .result        (ex_result),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .ex_mem        (ex_mem)
    );

    mem_stage u_mem (
        .clk        (clk),
        .rst        (rst),
        .en         (mem_en),
        .ex_mem     (ex_mem),
        .data_valid (data_valid),
        .data_ready (data_ready),
        .data_wr    (data_wr),
        .data_size  (data_size),
        .data_wstrb (data_wstrb),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_rdata (data_rdata),
        .fwd_value  (mem_value),
        .mem_wb     (mem_wb)
    );

    pipe_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .rs            (rs),
        .rt            (rt),
        .uses_rs       (uses_rs),
        .uses_rt       (uses_rt),
        .id_ex         (id_ex),
        .ex_mem        (ex_mem),
        .mem_wb        (mem_wb),
        .branch_taken  (branch_taken),
        .data_valid    (data_valid),
        .data_ready    (data_ready),
        .fetch_en      (fetch_en),
        .decode_en     (decode_en),
        .decode_flush  (decode_flush),
        .execute_en    (execute_en),
        .execute_flush (execute_flush),
        .mem_en        (mem_en),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b)
    );

    // decode already drops writes to r0
    assign debug_wb_pc       = mem_wb.pc;
    assign debug_wb_rf_wen   = {4{mem_wb.valid && mem_wb.reg_we}};
    assign debug_wb_rf_wnum  = mem_wb.dest;
    assign debug_wb_rf_wdata = mem_wb.wdata;

endmodule

// ==== dv/cpu_chk.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_chk (
    input logic               clk,
    input logic               rst,
    input cpu_pkg::word_t     inst_addr,
    input logic               data_valid,
    input logic               data_ready,
    input logic               data_wr,
    input cpu_pkg::word_t     data_addr,
    input cpu_pkg::word_t     data_wdata,
    input logic [3:0]         debug_wb_rf_wen,
    input cpu_pkg::reg_addr_t debug_wb_rf_wnum
);

    // quiet outputs right after a reset edge
    reset_state: assert property (@(posedge clk)
        rst |=> (!data_valid && debug_wb_rf_wen == 4'h0 && inst_addr == `CPU_RESET_PC))
        else $error("outputs not in reset state after reset");

    // a pending request holds until ready
    bus_hold: assert property (@(posedge clk) disable iff (rst)
        (data_valid && !data_ready) |=>
            (data_valid && $stable(data_wr) && $stable(data_addr) && $stable(data_wdata)))
        else $error("data bus request changed before ready");

    wen_nonzero: assert property (@(posedge clk) disable iff (rst)
        (debug_wb_rf_wen != 4'h0) |-> (debug_wb_rf_wnum != '0))
        else $error("register write to r0 shown on debug port");

endmodule

bind cpu_top cpu_chk chk0 (
    .clk              (clk),
    .rst              (rst),
    .inst_addr        (inst_addr),
    .data_valid       (data_valid),
    .data_ready       (data_ready),
    .data_wr          (data_wr),
    .data_addr        (data_addr),
    .data_wdata       (data_wdata),
    .debug_wb_rf_wen  (debug_wb_rf_wen),
    .debug_wb_rf_wnum (debug_wb_rf_wnum)
);

// ==== dv/cpu_tb.sv ====
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_tb;

    localparam int NUM_EXP    = 16;
    localparam int NUM_STORES = 2;
    localparam int MAX_CYCLES = 2000;

    logic               clk = 1'b0;
    logic               rst;
    cpu_pkg::word_t     inst_addr;
    cpu_pkg::inst_t     inst_line;
    logic               data_valid;
    logic               data_ready;
    logic               data_wr;
    logic [1:0]         data_size;
    logic [3:0]         data_wstrb;
    cpu_pkg::word_t     data_addr;
    cpu_pkg::word_t     data_wdata;
    cpu_pkg::word_t     data_rdata;
    cpu_pkg::word_t     debug_wb_pc;
    logic [3:0]         debug_wb_rf_wen;
    cpu_pkg::reg_addr_t debug_wb_rf_wnum;
    cpu_pkg::word_t     debug_wb_rf_wdata;

    cpu_pkg::inst_t     rom [0:31];
    cpu_pkg::word_t     dmem [0:63];
    cpu_pkg::word_t     exp_pc [0:NUM_EXP-1];
    cpu_pkg::reg_addr_t exp_reg [0:NUM_EXP-1];
    cpu_pkg::word_t     exp_val [0:NUM_EXP-1];
    cpu_pkg::word_t     st_addr [0:NUM_STORES-1];
    cpu_pkg::word_t     st_data [0:NUM_STORES-1];

    integer         seed = 32'hd895_c899;
    integer         errors = 0;
    integer         ret_idx = 0;
    integer         st_idx = 0;
    integer         wait_left = -1;
    integer         cycles;
    logic           held;
    logic           held_wr;
    cpu_pkg::word_t held_addr;
    cpu_pkg::word_t held_wdata;

    cpu_top dut0 (.*);

    function automatic cpu_pkg::inst_t enc_r(input logic [5:0] fn, input int rs, input int rt,
                                             input int rd);
        enc_r = {`OP_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic cpu_pkg::inst_t enc_i(input logic [5:0] op, input int rs, input int rt,
                                             input logic [15:0] imm);
        enc_i = {op, rs[4:0], rt[4:0], imm};
    endfunction

    // preset data words, every address bit matters
    function automatic cpu_pkg::word_t fill_word(input cpu_pkg::word_t a);
        fill_word = 32'h5a5a_5a5a ^ a ^ {a[15:0], a[31:16]};
    endfunction

    task automatic add_exp(input int i, input cpu_pkg::word_t pc, input int r,
                           input cpu_pkg::word_t v);
        exp_pc[i]  = pc;
        exp_reg[i] = r[4:0];
        exp_val[i] = v;
    endtask

    assign inst_line = rom[inst_addr[6:2]];

    initial
    begin
        forever #50 clk = ~clk;
    end

    initial
    begin
        for (int i = 0; i < 32; i++)
            rom[i] = '0;
        for (int i = 0; i < 64; i++)
            dmem[i] = fill_word(i * 4);
        rom[0]  = enc_i(`OP_LUI,   0, 1, 16'h1234);
        rom[1]  = enc_i(`OP_ORI,   1, 1, 16'h5678);
        rom[2]  = enc_i(`OP_ADDIU, 0, 2, 16'h0010);
        rom[3]  = enc_i(`OP_ADDIU, 0, 3, 16'hfffd);
        // r1 from writeback, r2 from memory stage
        rom[4]  = enc_r(`FN_ADDU, 1, 2, 4);
        rom[5]  = enc_r(`FN_SUBU, 4, 3, 5);
        rom[6]  = enc_r(`FN_AND,  5, 1, 6);
        rom[7]  = enc_r(`FN_OR,   6, 2, 7);
        rom[8]  = enc_r(`FN_XOR,  7, 1, 8);
        rom[9]  = enc_r(`FN_SLT,  3, 2, 9);
        rom[10] = enc_r(`FN_SLT,  2, 3, 10);
        rom[11] = enc_i(`OP_SW,    2, 4, 16'h0000);
        rom[12] = enc_i(`OP_LW,    2, 11, 16'h0000);
        // load then immediate use
        rom[13] = enc_r(`FN_ADDU, 11, 9, 12);
        rom[14] = enc_i(`OP_ADDIU, 0, 0, 16'h0005);
        rom[15] = enc_i(`OP_LW,    2, 13, 16'h0004);
        rom[16] = enc_i(`OP_BEQ,   13, 13, 16'h0002);
        rom[17] = enc_i(`OP_ADDIU, 0, 14, 16'h0001);
        rom[18] = enc_i(`OP_ADDIU, 0, 15, 16'h0002);
        rom[19] = enc_i(`OP_BNE,   1, 1, 16'h0002);
        rom[20] = enc_i(`OP_ADDIU, 0, 16, 16'h0007);
        rom[21] = enc_i(`OP_SW,    2, 16, 16'h0008);
        rom[22] = enc_i(`OP_LW,    2, 17, 16'h0000);
        // park in a self loop
        rom[23] = enc_i(`OP_BEQ,   0, 0, 16'hffff);

        add_exp(0,  32'h00, 1,  32'h1234_0000);
        add_exp(1,  32'h04, 1,  32'h1234_5678);
        add_exp(2,  32'h08, 2,  32'h0000_0010);
        add_exp(3,  32'h0c, 3,  32'hffff_fffd);
        add_exp(4,  32'h10, 4,  32'h1234_5688);
        add_exp(5,  32'h14, 5,  32'h1234_568b);
        add_exp(6,  32'h18, 6,  32'h1234_5608);
        add_exp(7,  32'h1c, 7,  32'h1234_5618);
        add_exp(8,  32'h20, 8,  32'h0000_0060);
        add_exp(9,  32'h24, 9,  32'h0000_0001);
        add_exp(10, 32'h28, 10, 32'h0000_0000);
        add_exp(11, 32'h30, 11, 32'h1234_5688);
        add_exp(12, 32'h34, 12, 32'h1234_5689);
        add_exp(13, 32'h3c, 13, 32'h5a4e_5a4e);
        add_exp(14, 32'h50, 16, 32'h0000_0007);
        add_exp(15, 32'h58, 17, 32'h1234_5688);
        st_addr[0] = 32'h10;
        st_data[0] = 32'h1234_5688;
        st_addr[1] = 32'h18;
        st_data[1] = 32'h0000_0007;
    end

    // memory model and retire checks, all on the falling edge
    always @(negedge clk)
    begin
        if (rst)
        begin
            assert (!data_valid && debug_wb_rf_wen == 4'h0) else
            begin
                errors++;
                $display("bus or write enable active during reset");
            end
            data_ready <= 1'b0;
            wait_left = -1;
            held = 1'b0;
        end
        else
        begin
            if (held)
            begin
                assert (data_valid && data_wr == held_wr && data_addr == held_addr &&
                        data_wdata == held_wdata) else
                begin
                    errors++;
                    $display("data bus request dropped or changed while waiting");
                end
            end

            if (debug_wb_rf_wen != 4'h0)
            begin
                assert (debug_wb_rf_wen == 4'hf && debug_wb_rf_wnum != '0) else
                begin
                    errors++;
                    $display("error: debug_wb_rf_wen = 0x%h, debug_wb_rf_wnum = 0x%h",
                             debug_wb_rf_wen, debug_wb_rf_wnum);
                end
                if (ret_idx >= NUM_EXP)
                begin
                    errors++;
                    $display("register write after the last expected one, pc 0x%08h",
                             debug_wb_pc);
                end
                else
                begin
                    assert (debug_wb_pc == exp_pc[ret_idx]) else
                    begin
                        errors++;
                        $display("error: debug_wb_pc = 0x%08h, expected 0x%08h",
                                 debug_wb_pc, exp_pc[ret_idx]);
                    end
                    assert (debug_wb_rf_wnum == exp_reg[ret_idx]) else
                    begin
                        errors++;
                        $display("error: debug_wb_rf_wnum = 0x%02h, expected 0x%02h",
                                 debug_wb_rf_wnum, exp_reg[ret_idx]);
                    end
                    assert (debug_wb_rf_wdata == exp_val[ret_idx]) else
                    begin
                        errors++;
                        $display("error: debug_wb_rf_wdata = 0x%08h, expected 0x%08h",
                                 debug_wb_rf_wdata, exp_val[ret_idx]);
                    end
                    ret_idx++;
                end
            end

            if (data_ready)
            begin
                data_ready <= 1'b0;
                wait_left = -1;
                held = 1'b0;
            end
            else if (data_valid)
            begin
                if (wait_left < 0)
                    wait_left = $unsigned($random(seed)) % 4;
                if (wait_left == 0)
                begin
                    data_ready <= 1'b1;
                    data_rdata <= dmem[data_addr[7:2]];
                    // every transfer is a whole word
                    assert (data_size == 2'b10) else
                    begin
                        errors++;
                        $display("error: data_size = 0x%h, expected 0x2", data_size);
                    end
                    if (data_wr)
                    begin
                        if (st_idx >= NUM_STORES)
                        begin
                            errors++;
                            $display("store issued after the last expected one");
                        end
                        else
                        begin
                            assert (data_wstrb == 4'hf) else
                            begin
                                errors++;
                                $display("error: data_wstrb = 0x%h, expected 0xf", data_wstrb);
                            end
                            assert (data_addr == st_addr[st_idx]) else
                            begin
                                errors++;
                                $display("error: data_addr = 0x%08h, expected 0x%08h",
                                         data_addr, st_addr[st_idx]);
                            end
                            assert (data_wdata == st_data[st_idx]) else
                            begin
                                errors++;
                                $display("error: data_wdata = 0x%08h, expected 0x%08h",
                                         data_wdata, st_data[st_idx]);
                            end
                            st_idx++;
                        end
                        dmem[data_addr[7:2]] = data_wdata;
                    end
                    held = 1'b0;
                end
                else
                begin
                    wait_left--;
                    held       = 1'b1;
                    held_wr    = data_wr;
                    held_addr  = data_addr;
                    held_wdata = data_wdata;
                end
            end
        end
    end

    initial
    begin
        rst        = 1'b1;
        data_ready <= 1'b0;
        data_rdata <= '0;
        held       = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        cycles = 0;
        while ((ret_idx < NUM_EXP || st_idx < NUM_STORES) && cycles < MAX_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end
        if (cycles >= MAX_CYCLES)
        begin
            errors++;
            $display("timed out waiting for the program to retire");
        end

        // idle in the self loop to catch stray writes
        repeat (20) @(posedge clk);
        @(negedge clk);

        $display("errors %0d, retired %0d of %0d, stores %0d of %0d",
                 errors, ret_idx, NUM_EXP, st_idx, NUM_STORES);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+source
source/cpu_pkg.sv
source/fetch_stage.sv
source/reg_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/mem_stage.sv
source/pipe_ctrl.sv
source/cpu_top.sv
dv/cpu_chk.sv
dv/cpu_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = cpu_tb
FILELIST = build.f
OBJDIR   = obj_dir
LOG      = sim.log
PASS     = ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS)" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
